// ==== rtl/spm_pkg.sv ====
// Shared widths, opcodes, bus select codes and FSM states of the SPM accumulator processor
package spm_pkg;

  localparam int WORD_W    = 16;
  localparam int ADDR_W    = 12;
  localparam int OP_W      = 4;
  localparam int MEM_DEPTH = 256;
  localparam int MEM_AW    = 8;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [MEM_AW-1:0] mem_addr_t;  // Low bits of addr_t
  typedef logic [OP_W-1:0]   opcode_t;    // Top nibble of the instruction word

  localparam opcode_t OP_ADD = 4'd0;
  localparam opcode_t OP_CMP = 4'd1;
  localparam opcode_t OP_LDA = 4'd2;
  localparam opcode_t OP_STA = 4'd3;
  localparam opcode_t OP_JMP = 4'd4;
  localparam opcode_t OP_JEZ = 4'd5;
  localparam opcode_t OP_JPS = 4'd6;
  localparam opcode_t OP_HLT = 4'd7;
  localparam opcode_t OP_INC = 4'd8;
  localparam opcode_t OP_DEC = 4'd9;
  localparam opcode_t OP_AND = 4'd10;
  localparam opcode_t OP_IOR = 4'd11;
  localparam opcode_t OP_SHL = 4'd12;
  localparam opcode_t OP_SHR = 4'd13;

  typedef logic [1:0] bus1_sel_t;
  typedef logic [1:0] bus2_sel_t;

  localparam bus1_sel_t BUS1_RA   = 2'd0;
  localparam bus1_sel_t BUS1_RB   = 2'd1;
  localparam bus1_sel_t BUS1_PC   = 2'd2;
  localparam bus2_sel_t BUS2_ALU  = 2'd0;
  localparam bus2_sel_t BUS2_BUS1 = 2'd1;
  localparam bus2_sel_t BUS2_MEM  = 2'd2;

  typedef enum logic [2:0] {
    ST_IDLE, ST_FET1, ST_FET2, ST_DECODE, ST_EXE1, ST_EXE2, ST_HALT
  } cpu_state_t;

endpackage

// ==== rtl/spm_loader.sv ====
// Program loader that fills memory from the host and tracks the run and halt status
`timescale 1ns/1ps

module spm_loader (
  input  logic               clk,
  input  logic               rst,
  input  logic               load_valid,
  output logic               load_ready,
  input  spm_pkg::mem_addr_t load_addr,
  input  spm_pkg::word_t     load_data,
  input  logic               run,
  output logic               halted,
  output logic               busy,
  input  logic               halt_req,
  input  logic               core_we,
  input  spm_pkg::mem_addr_t core_addr,
  input  spm_pkg::word_t     core_wdata,
  output logic               mem_we,
  output spm_pkg::mem_addr_t mem_waddr,
  output spm_pkg::word_t     mem_wdata
);

  assign load_ready = ~busy;  // Host may write only while the core is stopped

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      busy   <= 1'b0;
      halted <= 1'b0;
    end else if (busy && halt_req) begin
      busy   <= 1'b0;
      halted <= 1'b1;  // Held until the next run
    end else if (!busy && run) begin
      busy   <= 1'b1;
      halted <= 1'b0;
    end
  end

  // Single write port, core owns it while running
  always_comb begin
    if (busy) begin
      mem_we    = core_we;
      mem_waddr = core_addr;
      mem_wdata = core_wdata;
    end else begin
      mem_we    = load_valid && load_ready;
      mem_waddr = load_addr;
      mem_wdata = load_data;
    end
  end

endmodule

// ==== rtl/spm_memory.sv ====
// Unified program and data memory with combinational read and one clocked write port
`timescale 1ns/1ps

module spm_memory (
  input  logic               clk,
  input  logic               we,
  input  spm_pkg::mem_addr_t waddr,
  input  spm_pkg::word_t     wdata,
  input  spm_pkg::mem_addr_t raddr,
  output spm_pkg::word_t     rdata
);
  import spm_pkg::*;

  word_t mem [MEM_DEPTH];

  assign rdata = mem[raddr];  // Asynchronous read

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

endmodule

// ==== rtl/spm_datapath.sv ====
// Datapath with RA, RB, Y, Z, IR, PC and address register around two buses and the ALU
`timescale 1ns/1ps

module spm_datapath (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  logic               ld_ra,
  input  logic               ld_rb,
  input  logic               ld_y,
  input  logic               ld_z,
  input  logic               ld_ir,
  input  logic               ld_ar,
  input  logic               inc_pc,
  input  logic               jump_pc,
  input  spm_pkg::bus1_sel_t bus1_sel,
  input  spm_pkg::bus2_sel_t bus2_sel,
  input  spm_pkg::word_t     mem_rdata,
  output spm_pkg::mem_addr_t mem_addr,
  output spm_pkg::word_t     bus1,
  output spm_pkg::word_t     instr,
  output logic               zero
);
  import spm_pkg::*;

  word_t     ra;
  word_t     rb;
  word_t     y;
  word_t     bus2;
  word_t     alu_out;
  addr_t     pc;
  mem_addr_t ar;
  opcode_t   opcode;
  logic      ar_from_ir;

  assign opcode   = instr[WORD_W-1 -: OP_W];
  assign mem_addr = ar;

  // Fetch and LDA place the PC on bus 1, so STA is the only user of the IR field
  assign ar_from_ir = (opcode == OP_STA) && (bus1_sel != BUS1_PC);

  always_comb begin
    case (bus1_sel)
      BUS1_RA: bus1 = ra;
      BUS1_RB: bus1 = rb;
      BUS1_PC: bus1 = {{(WORD_W-ADDR_W){1'b0}}, pc};
      default: bus1 = '0;
    endcase
  end

  always_comb begin
    case (bus2_sel)
      BUS2_ALU:  bus2 = alu_out;
      BUS2_BUS1: bus2 = bus1;
      BUS2_MEM:  bus2 = mem_rdata;
      default:   bus2 = '0;
    endcase
  end

  // Two-operand ops take Y as the first operand, carries dropped
  always_comb begin
    case (opcode)
      OP_ADD:  alu_out = y + bus1;
      OP_AND:  alu_out = y & bus1;
      OP_IOR:  alu_out = y | bus1;
      OP_CMP:  alu_out = ~bus1;
      OP_INC:  alu_out = bus1 + 1'b1;
      OP_DEC:  alu_out = bus1 - 1'b1;
      OP_SHL:  alu_out = bus1 << 1;
      OP_SHR:  alu_out = bus1 >> 1;
      default: alu_out = bus1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (ld_y) y <= bus2;  // Operand latch
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      ra    <= '0;
      rb    <= '0;
      zero  <= 1'b0;
      instr <= '0;
      ar    <= '0;
      pc    <= '0;
    end else if (start) begin
      ra    <= '0;  // Fresh program run
      rb    <= '0;
      zero  <= 1'b0;
      instr <= '0;
      ar    <= '0;
      pc    <= '0;
    end else begin
      if (ld_ra) ra <= bus2;
      if (ld_rb) rb <= bus2;
      if (ld_z) zero <= ~|alu_out;
      if (ld_ir) instr <= bus2;
      if (ld_ar) ar <= ar_from_ir ? instr[MEM_AW-1:0] : bus2[MEM_AW-1:0];
      if (jump_pc) begin
        pc <= instr[ADDR_W-1:0];
      end else if (inc_pc) begin
        pc <= pc + 1'b1;
      end
    end
  end

endmodule

// ==== rtl/spm_control.sv ====
// Fetch, decode and execute FSM that drives the datapath loads, bus selects and writes
`timescale 1ns/1ps

module spm_control (
  input  logic               clk,
  input  logic               rst,
  input  logic               busy,
  input  spm_pkg::word_t     instr,
  input  logic               zero,
  input  logic               store_full,
  output logic               start,
  output logic               halt_req,
  output logic               store_push,
  output logic               mem_we,
  output logic               ld_ra,
  output logic               ld_rb,
  output logic               ld_y,
  output logic               ld_z,
  output logic               ld_ir,
  output logic               ld_ar,
  output logic               inc_pc,
  output logic               jump_pc,
  output spm_pkg::bus1_sel_t bus1_sel,
  output spm_pkg::bus2_sel_t bus2_sel
);
  import spm_pkg::*;

  cpu_state_t state;
  cpu_state_t next_state;
  opcode_t    opcode;

  assign opcode = instr[WORD_W-1 -: OP_W];

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state <= ST_IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    start      = 1'b0;
    halt_req   = 1'b0;
    store_push = 1'b0;
    mem_we     = 1'b0;
    ld_ra      = 1'b0;
    ld_rb      = 1'b0;
    ld_y       = 1'b0;
    ld_z       = 1'b0;
    ld_ir      = 1'b0;
    ld_ar      = 1'b0;
    inc_pc     = 1'b0;
    jump_pc    = 1'b0;
    bus1_sel   = BUS1_RA;
    bus2_sel   = BUS2_BUS1;
    case (state)
      ST_IDLE: begin
        if (busy) begin
          start      = 1'b1;  // PC back to 0
          next_state = ST_FET1;
        end
      end
      ST_FET1: begin
        bus1_sel   = BUS1_PC;
        ld_ar      = 1'b1;
        next_state = ST_FET2;
      end
      ST_FET2: begin
        bus2_sel   = BUS2_MEM;
        ld_ir      = 1'b1;
        inc_pc     = 1'b1;
        next_state = ST_DECODE;
      end
      ST_DECODE: begin
        if (opcode == OP_HLT) begin
          next_state = ST_HALT;
        end else if (opcode > OP_SHR) begin
          next_state = ST_FET1;  // Unused opcodes act as no-op
        end else begin
          next_state = ST_EXE1;
        end
      end
      ST_EXE1: begin
        next_state = ST_FET1;
        case (opcode)
          OP_ADD, OP_AND, OP_IOR: begin
            bus1_sel   = BUS1_RB;  // RB into Y first
            ld_y       = 1'b1;
            next_state = ST_EXE2;
          end
          OP_CMP, OP_INC, OP_DEC, OP_SHL, OP_SHR: begin
            bus2_sel = BUS2_ALU;
            ld_ra    = 1'b1;
            ld_z     = 1'b1;
          end
          OP_LDA: begin
            bus1_sel   = BUS1_PC;  // Operand word follows the instruction
            ld_ar      = 1'b1;
            next_state = ST_EXE2;
          end
          OP_STA: begin
            ld_ar      = 1'b1;  // Takes the IR address field
            next_state = ST_EXE2;
          end
          OP_JMP: jump_pc = 1'b1;
          OP_JEZ: jump_pc = zero;
          OP_JPS: jump_pc = ~zero;
          default: next_state = ST_FET1;
        endcase
      end
      ST_EXE2: begin
        next_state = ST_FET1;
        case (opcode)
          OP_ADD, OP_AND, OP_IOR: begin
            bus2_sel = BUS2_ALU;
            ld_ra    = 1'b1;
            ld_z     = 1'b1;
          end
          OP_LDA: begin
            bus2_sel = BUS2_MEM;
            ld_ra    = ~instr[0];
            ld_rb    = instr[0];
            inc_pc   = 1'b1;  // Skip the operand word
          end
          OP_STA: begin
            if (store_full) begin
              next_state = ST_EXE2;  // Stall on output back-pressure
            end else begin
              mem_we     = 1'b1;
              store_push = 1'b1;
            end
          end
          default: next_state = ST_FET1;
        endcase
      end
      ST_HALT: begin
        halt_req   = 1'b1;
        next_state = ST_IDLE;
      end
      default: next_state = ST_IDLE;
    endcase
  end

endmodule

// ==== rtl/spm_store_port.sv ====
// One-entry output buffer that presents STA results on a valid/ready port
`timescale 1ns/1ps

module spm_store_port (
  input  logic           clk,
  input  logic           rst,
  input  logic           push,
  input  spm_pkg::addr_t addr,
  input  spm_pkg::word_t data,
  output logic           store_full,
  output logic           store_valid,
  input  logic           store_ready,
  output spm_pkg::addr_t store_addr,
  output spm_pkg::word_t store_data
);

  logic full;

  assign store_full  = full;
  assign store_valid = full;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      full <= 1'b0;
    end else if (push) begin
      full <= 1'b1;  // Core never pushes while full
    end else if (full && store_ready) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      store_addr <= addr;
      store_data <= data;
    end
  end

endmodule

// ==== rtl/spm_top.sv ====
// SPM processor top level joining the loader, memory, core and store port
`timescale 1ns/1ps

module spm_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               load_valid,
  output logic               load_ready,
  input  spm_pkg::mem_addr_t load_addr,
  input  spm_pkg::word_t     load_data,
  input  logic               run,
  output logic               halted,
  output logic               store_valid,
  input  logic               store_ready,
  output spm_pkg::addr_t     store_addr,
  output spm_pkg::word_t     store_data
);
  import spm_pkg::*;

  logic      busy;
  logic      halt_req;
  logic      core_we;
  logic      mem_we;
  mem_addr_t mem_waddr;
  word_t     mem_wdata;
  mem_addr_t mem_raddr;
  word_t     mem_rdata;
  logic      start;
  logic      ld_ra;
  logic      ld_rb;
  logic      ld_y;
  logic      ld_z;
  logic      ld_ir;
  logic      ld_ar;
  logic      inc_pc;
  logic      jump_pc;
  bus1_sel_t bus1_sel;
  bus2_sel_t bus2_sel;
  word_t     bus1;
  word_t     instr;
  logic      zero;
  logic      store_push;
  logic      store_full;

  spm_loader i_loader (
    .clk        (clk),
    .rst        (rst),
    .load_valid (load_valid),
    .load_ready (load_ready),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .run        (run),
    .halted     (halted),
    .busy       (busy),
    .halt_req   (halt_req),
    .core_we    (core_we),
    .core_addr  (mem_raddr),  // STA target held in the address register
    .core_wdata (bus1),
    .mem_we     (mem_we),
    .mem_waddr  (mem_waddr),
    .mem_wdata  (mem_wdata)
  );

  spm_memory i_memory (
    .clk   (clk),
    .we    (mem_we),
    .waddr (mem_waddr),
    .wdata (mem_wdata),
    .raddr (mem_raddr),
    .rdata (mem_rdata)
  );

  spm_datapath i_datapath (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .ld_ra     (ld_ra),
    .ld_rb     (ld_rb),
    .ld_y      (ld_y),
    .ld_z      (ld_z),
    .ld_ir     (ld_ir),
    .ld_ar     (ld_ar),
    .inc_pc    (inc_pc),
    .jump_pc   (jump_pc),
    .bus1_sel  (bus1_sel),
    .bus2_sel  (bus2_sel),
    .mem_rdata (mem_rdata),
    .mem_addr  (mem_raddr),
    .bus1      (bus1),
    .instr     (instr),
    .zero      (zero)
  );

  spm_control i_control (
    .clk        (clk),
    .rst        (rst),
    .busy       (busy),
    .instr      (instr),
    .zero       (zero),
    .store_full (store_full),
    .start      (start),
    .halt_req   (halt_req),
    .store_push (store_push),
    .mem_we     (core_we),
    .ld_ra      (ld_ra),
    .ld_rb      (ld_rb),
    .ld_y       (ld_y),
    .ld_z       (ld_z),
    .ld_ir      (ld_ir),
    .ld_ar      (ld_ar),
    .inc_pc     (inc_pc),
    .jump_pc    (jump_pc),
    .bus1_sel   (bus1_sel),
    .bus2_sel   (bus2_sel)
  );

  spm_store_port i_store_port (
    .clk         (clk),
    .rst         (rst),
    .push        (store_push),
    .addr        (instr[ADDR_W-1:0]),
    .data        (bus1),
    .store_full  (store_full),
    .store_valid (store_valid),
    .store_ready (store_ready),
    .store_addr  (store_addr),
    .store_data  (store_data)
  );

endmodule

// ==== tests/spm_sva.sv ====
// Handshake, loader status and reset checks bound into the SPM processor top level
`timescale 1ns/1ps

module spm_sva (
  input logic                 clk,
  input logic                 rst,
  input logic                 busy,
  input logic                 load_ready,
  input logic                 halted,
  input logic                 store_valid,
  input logic                 store_ready,
  input spm_pkg::addr_t       store_addr,
  input spm_pkg::word_t       store_data,
  input spm_pkg::cpu_state_t  state
);
  import spm_pkg::*;

  // Stalled store item keeps its payload
  store_hold: assert property (@(posedge clk) disable iff (!rst)
    store_valid && !store_ready |=> store_valid && $stable(store_data) && $stable(store_addr))
    else $error("store_valid dropped or its payload changed before store_ready");

  load_block: assert property (@(posedge clk) disable iff (!rst)
    busy |-> !load_ready)
    else $error("load_ready is high while the core is busy");

  status_excl: assert property (@(posedge clk) disable iff (!rst)
    !(halted && busy))
    else $error("halted and busy are high together");

  halt_seen: assert property (@(posedge clk) disable iff (!rst)
    state == ST_HALT |=> halted)
    else $error("halted did not rise after the FSM reached its halt state");

  reset_clear: assert property (@(posedge clk)
    $rose(rst) |-> !store_valid && !halted)
    else $error("store_valid or halted is high right after reset");

endmodule

bind spm_top spm_sva i_sva (
  .clk         (clk),
  .rst         (rst),
  .busy        (busy),
  .load_ready  (load_ready),
  .halted      (halted),
  .store_valid (store_valid),
  .store_ready (store_ready),
  .store_addr  (store_addr),
  .store_data  (store_data),
  .state       (i_control.state)
);

// ==== tests/tb_spm.sv ====
// Testbench for the SPM processor that loads programs, runs them and checks the drained stores
`timescale 1ns/1ps

module tb_spm;
  import spm_pkg::*;

  localparam int LOAD_TIMEOUT = 50;
  localparam int RUN_TIMEOUT  = 3000;

  logic      clk;
  logic      rst;
  logic      load_valid;
  logic      load_ready;
  mem_addr_t load_addr;
  word_t     load_data;
  logic      run;
  logic      halted;
  logic      store_valid;
  logic      store_ready;
  addr_t     store_addr;
  word_t     store_data;

  word_t prog[$];
  word_t exp_data[$];
  addr_t exp_addr[$];
  word_t got_data[$];
  addr_t got_addr[$];

  int errors;
  int test_errors_start;
  int tests_run;
  int tests_failed;
  bit timed_out;

  spm_top i_dut (
    .clk         (clk),
    .rst         (rst),
    .load_valid  (load_valid),
    .load_ready  (load_ready),
    .load_addr   (load_addr),
    .load_data   (load_data),
    .run         (run),
    .halted      (halted),
    .store_valid (store_valid),
    .store_ready (store_ready),
    .store_addr  (store_addr),
    .store_data  (store_data)
  );

  always #50 clk = ~clk;

  function automatic word_t encode(input opcode_t op, input addr_t field);
    return {op, field};
  endfunction

  task automatic begin_test();
    prog.delete();
    exp_data.delete();
    exp_addr.delete();
    test_errors_start = errors;
  endtask

  task automatic expect_store(input addr_t addr, input word_t data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  // Each word goes to its own index, held until load_ready is seen
  task automatic load_program();
    int i;
    int wait_cnt;
    for (i = 0; i < prog.size() && !timed_out; i++) begin
      @(posedge clk);
      load_valid <= 1'b1;
      load_addr  <= mem_addr_t'(i);
      load_data  <= prog[i];
      @(negedge clk);
      wait_cnt = 0;
      while (!load_ready && wait_cnt < LOAD_TIMEOUT) begin
        @(negedge clk);
        wait_cnt++;
      end
      if (!load_ready) begin
        $display("Timeout: load_ready stayed low while loading word %0d", i);
        timed_out = 1'b1;
      end
    end
    @(posedge clk);
    load_valid <= 1'b0;
  endtask

  // Pulse run, then drain stores until halted with the buffer empty
  task automatic run_program(input int hold_low);
    int cycles;
    bit done;
    got_data.delete();
    got_addr.delete();
    @(posedge clk);
    run <= 1'b1;
    @(posedge clk);
    run    <= 1'b0;
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < RUN_TIMEOUT) begin
      @(posedge clk);
      store_ready <= (cycles >= hold_low) && ($urandom() % 2 == 0);
      @(negedge clk);
      cycles++;
      if (store_valid && store_ready) begin  // Transfer on the coming edge
        got_data.push_back(store_data);
        got_addr.push_back(store_addr);
      end
      done = halted && !store_valid;
    end
    if (!done) begin
      $display("Timeout: program did not halt and drain within %0d cycles", RUN_TIMEOUT);
      timed_out = 1'b1;
    end
  endtask

  task automatic check_stores(input string name);
    int i;
    assert (got_data.size() == exp_data.size()) else begin
      $display("ERR %s store count: expected %0d actual %0d",
               name, exp_data.size(), got_data.size());
      errors++;
    end
    for (i = 0; i < exp_data.size() && i < got_data.size(); i++) begin
      assert (got_data[i] == exp_data[i]) else begin
        $display("ERR %s store %0d data: expected %h actual %h",
                 name, i, exp_data[i], got_data[i]);
        errors++;
      end
      assert (got_addr[i] == exp_addr[i]) else begin
        $display("ERR %s store %0d addr: expected %h actual %h",
                 name, i, exp_addr[i], got_addr[i]);
        errors++;
      end
    end
    tests_run++;
    if (errors == test_errors_start && !timed_out) begin
      $display("Test %s: PASS", name);
    end else begin
      tests_failed++;
      $display("Test %s: FAIL", name);
    end
  endtask

  task automatic arith_test();
    word_t a;
    word_t b;
    a = 16'hA5C3;
    b = 16'h7F4E;
    begin_test();
    prog.push_back(encode(OP_LDA, 12'h000));  // Into RA
    prog.push_back(a);
    prog.push_back(encode(OP_LDA, 12'h001));  // Into RB
    prog.push_back(b);
    prog.push_back(encode(OP_ADD, 12'h000));
    prog.push_back(encode(OP_STA, 12'h080));
    prog.push_back(encode(OP_HLT, 12'h000));
    expect_store(12'h080, a + b);  // Carry out dropped
    load_program();
    run_program(0);
    check_stores("arith");
  endtask

  task automatic logic_test();
    word_t a;
    word_t b;
    word_t r;
    a = 16'hC3A5;
    b = 16'h0FF0;
    begin_test();
    prog.push_back(encode(OP_LDA, 12'h000));
    prog.push_back(a);
    prog.push_back(encode(OP_LDA, 12'h001));
    prog.push_back(b);
    prog.push_back(encode(OP_AND, 12'h000));
    prog.push_back(encode(OP_STA, 12'h081));
    prog.push_back(encode(OP_LDA, 12'h000));
    prog.push_back(a);
    prog.push_back(encode(OP_IOR, 12'h000));
    prog.push_back(encode(OP_STA, 12'h082));
    prog.push_back(encode(OP_CMP, 12'h000));
    prog.push_back(encode(OP_STA, 12'h083));
    prog.push_back(encode(OP_SHL, 12'h000));
    prog.push_back(encode(OP_STA, 12'h084));
    prog.push_back(encode(OP_SHR, 12'h000));
    prog.push_back(encode(OP_STA, 12'h085));
    prog.push_back(encode(OP_INC, 12'h000));
    prog.push_back(encode(OP_STA, 12'h086));
    prog.push_back(encode(OP_DEC, 12'h000));
    prog.push_back(encode(OP_STA, 12'h087));
    prog.push_back(encode(OP_HLT, 12'h000));
    r = a & b;
    expect_store(12'h081, r);
    r = a | b;
    expect_store(12'h082, r);
    r = ~r;
    expect_store(12'h083, r);
    r = r << 1;  // Top bit lost
    expect_store(12'h084, r);
    r = r >> 1;
    expect_store(12'h085, r);
    r = r + 1;
    expect_store(12'h086, r);
    r = r - 1;
    expect_store(12'h087, r);
    load_program();
    run_program(0);
    check_stores("logic");
  endtask

  task automatic branch_test();
    int i;
    int n;
    n = 5;
    begin_test();
    prog.push_back(encode(OP_LDA, 12'h000));
    prog.push_back(word_t'(n));
    prog.push_back(encode(OP_DEC, 12'h000));  // Loop top at 2
    prog.push_back(encode(OP_STA, 12'h090));
    prog.push_back(encode(OP_JPS, 12'h002));
    prog.push_back(encode(OP_JEZ, 12'h007));
    prog.push_back(encode(OP_STA, 12'h091));  // Skipped by JEZ
    prog.push_back(encode(OP_JMP, 12'h009));
    prog.push_back(encode(OP_STA, 12'h092));  // Skipped by JMP
    prog.push_back(encode(OP_STA, 12'h093));
    prog.push_back(encode(OP_HLT, 12'h000));
    for (i = n - 1; i >= 0; i--) begin
      expect_store(12'h090, word_t'(i));
    end
    expect_store(12'h093, 16'h0000);
    load_program();
    run_program(0);
    check_stores("branch");
  endtask

  task automatic backpressure_test();
    word_t x;
    int    i;
    x = 16'hFFFE;  // Wraps through zero
    begin_test();
    prog.push_back(encode(OP_LDA, 12'h000));
    prog.push_back(x);
    for (i = 0; i < 4; i++) begin
      prog.push_back(encode(OP_STA, addr_t'(12'h0A0 + i)));
      prog.push_back(encode(OP_INC, 12'h000));
      expect_store(addr_t'(12'h0A0 + i), x + word_t'(i));
    end
    prog.push_back(encode(OP_HLT, 12'h000));
    load_program();
    run_program(60);  // Ready held low over several STAs
    check_stores("backpressure");
  endtask

  task automatic reload_test();
    word_t c;
    word_t d;
    c = 16'h3C5A;
    d = 16'hF0F0;
    begin_test();
    @(negedge clk);
    assert (halted && load_ready) else begin
      $display("Loader did not return to the stopped state after halt");
      errors++;
    end
    prog.push_back(encode(OP_LDA, 12'h000));
    prog.push_back(c);
    prog.push_back(encode(OP_LDA, 12'h001));
    prog.push_back(d);
    prog.push_back(encode(OP_AND, 12'h000));
    prog.push_back(encode(OP_STA, 12'h0B0));
    prog.push_back(encode(OP_SHL, 12'h000));
    prog.push_back(encode(OP_STA, 12'h0B1));
    prog.push_back(encode(OP_HLT, 12'h000));
    expect_store(12'h0B0, c & d);
    expect_store(12'h0B1, (c & d) << 1);
    load_program();
    run_program(0);
    check_stores("reload");
  endtask

  initial begin
    int unsigned seed_val;
    clk          = 1'b0;
    rst          = 1'b0;
    load_valid   = 1'b0;
    load_addr    = '0;
    load_data    = '0;
    run          = 1'b0;
    store_ready  = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    seed_val     = $urandom(5);
    repeat (5) @(posedge clk);
    rst <= 1'b1;
    if (!timed_out) arith_test();
    if (!timed_out) logic_test();
    if (!timed_out) branch_test();
    if (!timed_out) backpressure_test();
    if (!timed_out) reload_test();  // Follows the halt of the previous run
    $display("Summary: %0d tests run, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0 && !timed_out) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== spm.f ====
rtl/spm_pkg.sv
rtl/spm_loader.sv
rtl/spm_memory.sv
rtl/spm_datapath.sv
rtl/spm_control.sv
rtl/spm_store_port.sv
rtl/spm_top.sv
tests/spm_sva.sv
tests/tb_spm.sv

// ==== Bender.yml ====
package:
  name: spm

sources:
  - rtl/spm_pkg.sv
  - rtl/spm_loader.sv
  - rtl/spm_memory.sv
  - rtl/spm_datapath.sv
  - rtl/spm_control.sv
  - rtl/spm_store_port.sv
  - rtl/spm_top.sv
  - target: test
    files:
      - tests/spm_sva.sv
      - tests/tb_spm.sv
